// File: include/pdp8_defs.svh
`ifndef PDP8_DEFS_SVH
`define PDP8_DEFS_SVH

// word and page geometry
`define PDP8_WORD_W      12
`define PDP8_PAGE_DEPTH  128
`define PDP8_OFFSET_W    7

// major opcodes, instruction bits 0..2
`define PDP8_OP_AND  3'o0
`define PDP8_OP_TAD  3'o1
`define PDP8_OP_DCA  3'o3
`define PDP8_OP_IOT  3'o6
`define PDP8_OP_OPR  3'o7

`endif

// File: src/pdp8_pkg.sv
`default_nettype none

`include "pdp8_defs.svh"

package pdp8_pkg;

    // major states, fetch phases then execute phases
    typedef enum logic [3:0] {
        IDLE,
        F0,
        F1,
        F2,
        F3,
        E0,
        E1,
        E2,
        E3,
        DONE
    } major_state_e;

    typedef struct packed {
        logic [0:2]                  opcode;
        logic                        indirect;   // not supported, ignored
        logic                        page;       // page zero only
        logic [0:`PDP8_OFFSET_W-1]   offset;
    } pdp8_mri_t;

    // one instruction word, two decodings
    typedef union packed {
        pdp8_mri_t                   mri;
        logic [0:`PDP8_WORD_W-1]     opr;        // operate / IOT bits
    } pdp8_instr_u;

    typedef struct packed {
        pdp8_instr_u                 instr;
        logic [0:`PDP8_WORD_W-1]     data;       // stands in for the input bus
    } pdp8_cmd_t;

    typedef struct packed {
        logic [0:`PDP8_WORD_W-1]     ac;
        logic                        l;
        logic [0:`PDP8_WORD_W-1]     mq;
        logic                        gtf;
    } pdp8_result_t;

endpackage

`default_nettype wire

// File: src/pdp8_major_state.sv
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_major_state (
    input  logic                          clk,
    input  logic                          arst_n,
    input  pdp8_pkg::pdp8_cmd_t           cmd,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    output logic                          result_valid,
    input  logic                          result_ready,
    output pdp8_pkg::major_state_e        state,
    output pdp8_pkg::pdp8_cmd_t           held_cmd,
    output logic [`PDP8_OFFSET_W-1:0]     mem_addr
);
    import pdp8_pkg::*;

    major_state_e state_nxt;

    assign cmd_ready    = (state == IDLE);
    assign result_valid = (state == DONE);
    assign mem_addr     = held_cmd.instr.mri.offset;  // page zero

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (cmd_valid) state_nxt = F0;
            F0:   state_nxt = F1;
            F1:   state_nxt = F2;
            F2:   state_nxt = F3;
            F3:   state_nxt = (held_cmd.instr.mri.opcode < `PDP8_OP_IOT) ? E0 : DONE;
            E0:   state_nxt = E1;
            E1:   state_nxt = E2;
            E2:   state_nxt = E3;
            E3:   state_nxt = DONE;
            DONE: if (result_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // command word held for the whole instruction
    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_valid) begin
            held_cmd <= cmd;
        end
    end

endmodule

`default_nettype wire

// File: src/pdp8_ac_unit.sv
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_ac_unit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  pdp8_pkg::major_state_e        state,
    input  pdp8_pkg::pdp8_cmd_t           held_cmd,
    input  logic [0:`PDP8_WORD_W-1]       sr,
    input  logic [0:`PDP8_WORD_W-1]       rd_data,
    output pdp8_pkg::pdp8_result_t        result,
    output logic                          mem_we,
    output logic [0:`PDP8_WORD_W-1]       mem_wdata
);
    import pdp8_pkg::*;

    logic [0:`PDP8_WORD_W-1]  ac;
    logic                     l;
    logic [0:`PDP8_WORD_W-1]  mq;
    logic                     gtf;
    logic [0:`PDP8_WORD_W-1]  operand;     // memory operand from E1

    pdp8_instr_u              instr;
    logic                     is_opr;
    logic                     is_iot;
    logic                     grp1;
    logic                     grp2;
    logic                     grp3;

    logic [0:`PDP8_WORD_W-1]  g1_ac;
    logic                     g1_l;
    logic [0:`PDP8_WORD_W-1]  g3_base;
    logic [0:`PDP8_WORD_W-1]  g3_ac;
    logic [0:`PDP8_WORD_W-1]  g3_mq;
    logic [0:`PDP8_WORD_W]    link_ac;
    logic [0:`PDP8_WORD_W]    rot_link_ac;

    assign instr  = held_cmd.instr;
    assign is_opr = (instr.mri.opcode == `PDP8_OP_OPR);
    assign is_iot = (instr.mri.opcode == `PDP8_OP_IOT);
    assign grp1   = is_opr && !instr.opr[3];
    assign grp2   = is_opr && instr.opr[3] && !instr.opr[11];
    assign grp3   = is_opr && instr.opr[3] && instr.opr[11];

    // group 1 clear then complement, bits 4..7 = CLA CLL CMA CML
    always_comb begin
        g1_ac = instr.opr[4] ? '0 : ac;
        g1_l  = instr.opr[5] ? 1'b0 : l;
        if (instr.opr[6]) g1_ac = ~g1_ac;
        if (instr.opr[7]) g1_l  = ~g1_l;
    end

    // group 3, bit 4 CLA, bit 5 MQA, bit 7 MQL
    always_comb begin
        g3_base = instr.opr[4] ? '0 : ac;
        g3_ac   = (instr.opr[5] ? mq : '0) | (instr.opr[7] ? '0 : g3_base);
        g3_mq   = instr.opr[7] ? g3_base : mq;
    end

    // group 1 rotates on the 13-bit link and AC, bits 8..10 = RAR RAL BSW
    assign link_ac = {l, ac};

    always_comb begin
        casez (instr.opr[8:10])
            3'b001:  rot_link_ac = {l, ac[6:11], ac[0:5]};                   // BSW
            3'b010:  rot_link_ac = {link_ac[1:12], link_ac[0]};              // RAL
            3'b011:  rot_link_ac = {link_ac[2:12], link_ac[0:1]};            // RTL
            3'b100:  rot_link_ac = {link_ac[12], link_ac[0:11]};             // RAR
            3'b101:  rot_link_ac = {link_ac[11:12], link_ac[0:10]};          // RTR
            default: rot_link_ac = link_ac;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ac  <= '0;
            l   <= 1'b0;
            mq  <= '0;
            gtf <= 1'b0;
        end else begin
            case (state)
                F1: begin
                    if (instr.opr == 12'o6007) begin      // CAF
                        ac  <= '0;
                        l   <= 1'b0;
                        gtf <= 1'b0;
                    end else if (grp1) begin
                        ac <= g1_ac;
                        l  <= g1_l;
                    end
                end
                F2: begin
                    if (grp3) begin
                        ac <= g3_ac;
                        mq <= g3_mq;
                    end else if (grp2 && instr.opr[4]) begin
                        ac <= '0;                         // group 2 CLA
                    end else if (grp1 && instr.opr[11]) begin
                        {l, ac} <= link_ac + 13'd1;       // IAC, carry flips L
                    end
                end
                F3: begin
                    if (grp2 && instr.opr[9]) begin
                        ac <= ac | sr;                    // OSR
                    end else if (is_iot) begin
                        casez (instr.opr)
                            12'o6004: ac <= {l, gtf, held_cmd.data[2:11]};
                            12'o6005: {l, gtf} <= ac[0:1];
                            12'o6032: ac <= '0;
                            12'o6034: ac <= ac | held_cmd.data;
                            12'o6036, 12'o6214, 12'o6224, 12'o6234:
                                ac <= held_cmd.data;
                            default: ;
                        endcase
                    end else if (grp1) begin
                        {l, ac} <= rot_link_ac;
                    end
                end
                E2: begin
                    if (instr.mri.opcode == `PDP8_OP_AND) begin
                        ac <= ac & operand;
                    end else if (instr.mri.opcode == `PDP8_OP_TAD) begin
                        {l, ac} <= link_ac + {1'b0, operand};
                    end
                end
                E3: begin
                    if (instr.mri.opcode == `PDP8_OP_DCA) ac <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E1) operand <= rd_data;      // RAM data valid one cycle after E0
    end

    // DCA writes the old AC at the end of E3
    assign mem_we    = (state == E3) && (instr.mri.opcode == `PDP8_OP_DCA);
    assign mem_wdata = ac;

    assign result.ac  = ac;
    assign result.l   = l;
    assign result.mq  = mq;
    assign result.gtf = gtf;

endmodule

`default_nettype wire

// File: src/pdp8_page_ram.sv
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_page_ram (
    input  logic                          clk,
    input  logic [`PDP8_OFFSET_W-1:0]     addr,
    input  logic                          we,
    input  logic [0:`PDP8_WORD_W-1]       wdata,
    output logic [0:`PDP8_WORD_W-1]       rd_data
);

    logic [0:`PDP8_WORD_W-1] mem [`PDP8_PAGE_DEPTH];   // page zero

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rd_data <= mem[addr];       // read before write
    end

endmodule

`default_nettype wire

// File: src/pdp8_exec_top.sv
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_exec_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  pdp8_pkg::pdp8_cmd_t           cmd,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    output pdp8_pkg::pdp8_result_t        result,
    output logic                          result_valid,
    input  logic                          result_ready,
    input  logic [0:`PDP8_WORD_W-1]       sr
);
    import pdp8_pkg::*;

    major_state_e                 state;
    pdp8_cmd_t                    held_cmd;
    logic [`PDP8_OFFSET_W-1:0]    mem_addr;
    logic                         mem_we;
    logic [0:`PDP8_WORD_W-1]      mem_wdata;
    logic [0:`PDP8_WORD_W-1]      rd_data;

    pdp8_major_state u_major_state (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .state        (state),
        .held_cmd     (held_cmd),
        .mem_addr     (mem_addr)
    );

    pdp8_ac_unit u_ac_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .state     (state),
        .held_cmd  (held_cmd),
        .sr        (sr),
        .rd_data   (rd_data),
        .result    (result),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata)
    );

    pdp8_page_ram u_page_ram (
        .clk     (clk),
        .addr    (mem_addr),
        .we      (mem_we),
        .wdata   (mem_wdata),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: tb/pdp8_clock_gen.sv
`default_nettype none

module pdp8_clock_gen (
    output logic clk
);

    initial clk = 1'b0;

    always #20 clk = ~clk;      // 40-unit period

endmodule

`default_nettype wire

// File: tb/pdp8_exec_assertions.sv
`default_nettype none

module pdp8_exec_assertions (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cmd_ready,
    input  pdp8_pkg::pdp8_result_t      result,
    input  logic                        result_valid,
    input  logic                        result_ready,
    input  logic                        mem_we,
    input  pdp8_pkg::major_state_e      state
);
    import pdp8_pkg::*;

    ready_excl: assert property (@(posedge clk) !(cmd_ready && result_valid))
        else $error("cmd_ready and result_valid were high together");

    // stalled result must not move
    result_hold: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result changed before the result handshake");

    we_in_e3: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> state == E3)
        else $error("mem_we was high outside E3");

    reset_values: assert property (@(posedge clk)
        $rose(arst_n) |-> cmd_ready && !result_valid && !mem_we && result == '0)
        else $error("outputs were not at their reset values after reset");

endmodule

bind pdp8_exec_top pdp8_exec_assertions u_exec_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .mem_we       (mem_we),
    .state        (state)
);

`default_nettype wire

// File: tb/pdp8_exec_tb.sv
`default_nettype none

`include "pdp8_defs.svh"

module pdp8_exec_tb;
    import pdp8_pkg::*;

    localparam int MAX_VECTORS = 64;
    localparam int CLK_PERIOD  = 40;

    logic                clk;
    logic                arst_n;
    pdp8_cmd_t           cmd;
    logic                cmd_valid;
    logic                cmd_ready;
    pdp8_result_t        result;
    logic                result_valid;
    logic                result_ready;
    logic [11:0]         sr;

    logic [8*16-1:0]     vec_name  [MAX_VECTORS];
    logic [11:0]         vec_instr [MAX_VECTORS];
    logic [11:0]         vec_data  [MAX_VECTORS];
    logic [11:0]         vec_ac    [MAX_VECTORS];
    logic                vec_l     [MAX_VECTORS];
    logic [11:0]         vec_mq    [MAX_VECTORS];
    logic                vec_gtf   [MAX_VECTORS];
    int                  num_vectors = 0;
    int                  error_count = 0;
    logic                vectors_loaded = 1'b0;

    pdp8_clock_gen u_clock_gen (.clk(clk));

    pdp8_exec_top u_pdp8_exec_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .sr           (sr)
    );

    task automatic abort_run(input string reason);
        error_count++;
        $display("%0s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #5;                     // drive point after the edge
    endtask

    task automatic load_vectors;
        int                fd;
        int                code;
        string             line;
        logic [8*16-1:0]   name;
        logic [11:0]       f_instr, f_data, f_ac, f_l, f_mq, f_gtf;
        fd = $fopen("tb/pdp8_exec_input.txt", "r");
        if (fd == 0) abort_run("could not open the vector file tb/pdp8_exec_input.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin       // skip comments and blanks
                code = $sscanf(line, "%s %o %o %o %o %o %o", name, f_instr, f_data,
                               f_ac, f_l, f_mq, f_gtf);
                if (code != 7 || num_vectors >= MAX_VECTORS)
                    abort_run($sformatf("bad or surplus vector line: %0s", line));
                vec_name[num_vectors]  = name;
                vec_instr[num_vectors] = f_instr;
                vec_data[num_vectors]  = f_data;
                vec_ac[num_vectors]    = f_ac;
                vec_l[num_vectors]     = f_l[0];
                vec_mq[num_vectors]    = f_mq;
                vec_gtf[num_vectors]   = f_gtf[0];
                num_vectors++;
            end
        end
        $fclose(fd);
        if (num_vectors == 0) abort_run("the vector file holds no vectors");
    endtask

    task automatic check_field(input int idx, input string what, input int expected,
                               input int actual);
        assert (actual == expected) else
            abort_run($sformatf("[FAIL] %0s %0s: expected 0o%0o, got 0o%0o",
                                vec_name[idx], what, expected, actual));
    endtask

    task automatic run_vector(input int idx);
        int         latency;
        int         exp_latency;
        int         stall;
        logic [2:0] opcode;
        cmd.instr.opr = vec_instr[idx];
        cmd.data      = vec_data[idx];
        cmd_valid     = 1'b1;
        while (!cmd_ready) next_cycle();
        next_cycle();                       // accepted on this edge
        cmd_valid = 1'b0;
        latency   = 1;                      // F0 is the first cycle
        while (!result_valid) begin
            next_cycle();
            latency++;
        end
        // memory reference adds the four execute phases
        opcode      = vec_instr[idx][11:9];
        exp_latency = (opcode == `PDP8_OP_AND || opcode == `PDP8_OP_TAD ||
                       opcode == `PDP8_OP_DCA) ? 9 : 5;
        assert (latency == exp_latency) else
            abort_run($sformatf("[FAIL] %0s latency: expected %0d cycles, got %0d",
                                vec_name[idx], exp_latency, latency));
        stall = $urandom % 4;
        repeat (stall) begin
            assert (!cmd_ready) else abort_run("cmd_ready rose while a result was pending");
            next_cycle();
        end
        check_field(idx, "ac", int'(vec_ac[idx]), int'(result.ac));
        check_field(idx, "l", int'(vec_l[idx]), int'(result.l));
        check_field(idx, "mq", int'(vec_mq[idx]), int'(result.mq));
        check_field(idx, "gtf", int'(vec_gtf[idx]), int'(result.gtf));
        result_ready = 1'b1;
        next_cycle();
        result_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(93073));
        arst_n       = 1'b0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        result_ready = 1'b0;
        sr           = 12'o5252;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (16) @(posedge clk);
        #5 arst_n = 1'b1;
        for (int i = 0; i < num_vectors; i++) begin
            run_vector(i);
        end
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // execute path, worst stall and two handshakes per vector, plus reset
    initial begin
        wait (vectors_loaded);
        #((num_vectors * (9 + 4 + 2) + 16) * CLK_PERIOD);
        abort_run("timeout: the DUT stopped completing commands");
    end

endmodule

`default_nettype wire

// File: tb/pdp8_exec_input.txt
# name instr data | expected ac l mq gtf, all octal, state carries over between lines
# sr is 5252, page RAM starts unwritten so DCA comes before TAD and AND
ld_7777      6036 7777  7777 0 0000 0
iac_carry    7001 0000  0000 1 0000 0
cla_cll_cma  7340 0000  7777 0 0000 0
cml          7020 0000  7777 1 0000 0
ld_1234      6214 1234  1234 1 0000 0
ral          7004 0000  2471 0 0000 0
rtl          7006 0000  2344 1 0000 0
rar          7010 0000  5162 0 0000 0
rtr          7012 0000  1234 1 0000 0
bsw          7002 0000  3412 1 0000 0
cia          7041 0000  4366 1 0000 0
dca_10       3010 0000  0000 1 0000 0
ld_4000      6224 4000  4000 1 0000 0
tad_10       1010 0000  0366 0 0000 0
ld_7070      6234 7070  7070 0 0000 0
and_10       0010 0000  4060 0 0000 0
mql          7421 0000  0000 0 4060 0
ld_1111      6036 1111  1111 0 4060 0
mqa          7501 0000  5171 0 4060 0
swp          7521 0000  4060 0 5171 0
acl          7701 0000  5171 0 5171 0
cla_swp      7721 0000  5171 0 0000 0
or_4400      6034 4400  5571 0 0000 0
or_0077      6034 0077  5577 0 0000 0
iot_clr      6032 0000  0000 0 0000 0
ld_2525      6036 2525  2525 0 0000 0
rtf          6005 0000  2525 0 0000 1
gtf_to_ac    6004 1234  3234 0 0000 1
caf          6007 0000  0000 0 0000 0
cla_osr      7604 0000  5252 0 0000 0
ld_0101      6036 0101  0101 0 0000 0
osr          7404 0000  5353 0 0000 0

// File: verilog.f
+incdir+include
src/pdp8_pkg.sv
src/pdp8_major_state.sv
src/pdp8_ac_unit.sv
src/pdp8_page_ram.sv
src/pdp8_exec_top.sv
tb/pdp8_clock_gen.sv
tb/pdp8_exec_assertions.sv
tb/pdp8_exec_tb.sv

// File: Makefile
TOP := pdp8_exec_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
